// ==== hdl/max3421_pkg.sv ====
package max3421_pkg;

  // MAX3421E register numbers, shifted into bits 7:3 of the command byte
  typedef logic [4:0] reg_addr_t;

  localparam reg_addr_t REG_SUDFIFO = 5'd4;
  localparam reg_addr_t REG_RCVBC   = 5'd6;
  localparam reg_addr_t REG_USBIRQ  = 5'd13;
  localparam reg_addr_t REG_USBCTL  = 5'd15;
  localparam reg_addr_t REG_PINCTL  = 5'd17;
  localparam reg_addr_t REG_IOPINS1 = 5'd20;
  localparam reg_addr_t REG_HIRQ    = 5'd25;
  localparam reg_addr_t REG_HIEN    = 5'd26;
  localparam reg_addr_t REG_MODE    = 5'd27;
  localparam reg_addr_t REG_PERADDR = 5'd28;
  localparam reg_addr_t REG_HCTL    = 5'd29;
  localparam reg_addr_t REG_HXFR    = 5'd30;
  localparam reg_addr_t REG_HRSL    = 5'd31;

  // Direction bit of the command byte, set for a register write
  localparam int DIR_WRITE = 1;

  // Message bytes, command byte first
  typedef logic [7:0] msg_byte_t;
  localparam int MAX_MSG_BYTES = 9;
  typedef logic [3:0] msg_len_t;
  typedef msg_byte_t [MAX_MSG_BYTES-1:0] msg_bytes_t;

  // Every transaction the sequencer can issue
  typedef enum logic [4:0] {
    CMD_FULLDUPLEX,
    CMD_CHIP_RESET,
    CMD_CHIP_UNRESET,
    CMD_READ_USBIRQ,
    CMD_POWER,
    CMD_HOSTMODE,
    CMD_IRQ_ENABLE,
    CMD_SAMPLEBUS,
    CMD_BUSRESET,
    CMD_READ_HCTL,
    CMD_SOF,
    CMD_READ_HIRQ,
    CMD_SETUP_ADDR,
    CMD_HXFR_SETUP,
    CMD_CLEAR_HIRQ,
    CMD_HXFR_STATUS,
    CMD_READ_HRSL,
    CMD_WRITE_PERADDR
  } cmd_t;

  // HRSLT field of HRSL
  localparam logic [3:0] HRSLT_SUCCESS = 4'd0;
  localparam logic [3:0] HRSLT_NAK     = 4'd4;

  // Poll bits in the returned register value
  localparam int OSCOKIRQ_BIT = 0;
  localparam int BUSRST_BIT   = 0;
  localparam int FRAMEIRQ_BIT = 6;

  // Address handed to the device by SET_ADDRESS
  localparam msg_byte_t PERIPH_ADDR = 8'd1;

  // Delays in clk_in cycles
  typedef logic [20:0] wait_count_t;
  localparam wait_count_t SETTLE_CYCLES     = 21'd1_250_000;
  localparam wait_count_t SOF_SETTLE_CYCLES = 21'd120_000;
  localparam wait_count_t FIFO_GAP_CYCLES   = 21'd10;
  localparam wait_count_t XFR_WAIT_CYCLES   = 21'd20;
  localparam wait_count_t STATUS_GAP_CYCLES = 21'd10;
  localparam wait_count_t ADDR_REST_CYCLES  = 21'd190_000;

  // SPI clocking, clk_in cycles per SCLK half period
  localparam int SPI_HALF_CYCLES = 8;
  typedef logic [$clog2(SPI_HALF_CYCLES)-1:0] half_count_t;
  localparam half_count_t HALF_LAST = half_count_t'(SPI_HALF_CYCLES - 1);

  // Minimum n_ss high time between frames
  typedef logic [$clog2(2 * SPI_HALF_CYCLES + 1)-1:0] gap_count_t;
  localparam gap_count_t SPI_GAP_CYCLES = gap_count_t'(2 * SPI_HALF_CYCLES);

endpackage

// ==== hdl/max3421_msg_rom.sv ====
`timescale 1ns/1ns

module max3421_msg_rom (
  input  max3421_pkg::cmd_t       cmd,
  output max3421_pkg::msg_bytes_t msg,
  output max3421_pkg::msg_len_t   msg_len
);
  import max3421_pkg::*;

  // Register number in bits 7:3, direction flag below it
  function automatic msg_byte_t cmd_byte(input reg_addr_t addr, input logic write);
    msg_byte_t b;
    b = {addr, 3'b000};
    b[DIR_WRITE] = write;
    return b;
  endfunction

  // Two byte register write
  function automatic msg_bytes_t write_msg(input reg_addr_t addr, input msg_byte_t data);
    msg_bytes_t m;
    m = '0;
    m[0] = cmd_byte(addr, 1'b1);
    m[1] = data;
    return m;
  endfunction

  // Register read, the second byte only clocks the value back
  function automatic msg_bytes_t read_msg(input reg_addr_t addr);
    msg_bytes_t m;
    m = '0;
    m[0] = cmd_byte(addr, 1'b0);
    return m;
  endfunction

  always_comb begin
    msg = '0;
    msg_len = 4'd2;
    case (cmd)
      // FDUPSPI and POSINT
      CMD_FULLDUPLEX:    msg = write_msg(REG_PINCTL, 8'h14);
      // CHIPRES set, then cleared
      CMD_CHIP_RESET:    msg = write_msg(REG_USBCTL, 8'h20);
      CMD_CHIP_UNRESET:  msg = write_msg(REG_USBCTL, 8'h00);
      CMD_READ_USBIRQ:   msg = read_msg(REG_USBIRQ);
      // GPOUT0 switches VBUS on
      CMD_POWER:         msg = write_msg(REG_IOPINS1, 8'h01);
      // DPPULLDN, DMPULLDN, SEPIRQ, HOST
      CMD_HOSTMODE:      msg = write_msg(REG_MODE, 8'hD9);
      CMD_IRQ_ENABLE:    msg = write_msg(REG_HIEN, 8'h60);
      CMD_SAMPLEBUS:     msg = write_msg(REG_HCTL, 8'h04);
      CMD_BUSRESET:      msg = write_msg(REG_HCTL, 8'h01);
      CMD_READ_HCTL:     msg = read_msg(REG_HCTL);
      // Same MODE value again, SOFKAENAB stays with host mode
      CMD_SOF:           msg = write_msg(REG_MODE, 8'hD9);
      CMD_READ_HIRQ:     msg = read_msg(REG_HIRQ);
      CMD_SETUP_ADDR: begin
        // SET_ADDRESS request, bRequest 0x05, wValue holds the address
        msg[0] = cmd_byte(REG_SUDFIFO, 1'b1);
        msg[2] = 8'h05;
        msg[3] = PERIPH_ADDR;
        msg_len = 4'd9;
      end
      // SETUP token, then the HS-IN handshake
      CMD_HXFR_SETUP:    msg = write_msg(REG_HXFR, 8'h10);
      CMD_CLEAR_HIRQ:    msg = write_msg(REG_HIRQ, 8'hE0);
      CMD_HXFR_STATUS:   msg = write_msg(REG_HXFR, 8'h80);
      CMD_READ_HRSL:     msg = read_msg(REG_HRSL);
      CMD_WRITE_PERADDR: msg = write_msg(REG_PERADDR, PERIPH_ADDR);
      default:           msg = '0;
    endcase
  end

endmodule

// ==== hdl/max3421_spi.sv ====
`timescale 1ns/1ns

module max3421_spi (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    spi_start,
  input  max3421_pkg::msg_bytes_t msg,
  input  max3421_pkg::msg_len_t   msg_len,
  input  logic                    miso,
  output logic                    sclk,
  output logic                    mosi,
  output logic                    n_ss,
  output logic                    spi_done,
  output max3421_pkg::msg_byte_t  rx_status,
  output max3421_pkg::msg_byte_t  rx_value
);
  import max3421_pkg::*;

  // Message held from the start pulse
  msg_bytes_t  msg_q;
  msg_len_t    len_q;

  // Frame control
  logic        busy;
  logic        tail;
  half_count_t half_cnt;
  logic [2:0]  bit_cnt;
  msg_len_t    byte_idx;

  // Shift registers
  msg_byte_t   tx_shift;
  msg_byte_t   rx_shift;

  msg_len_t    next_idx;
  msg_byte_t   next_byte;
  logic        half_end;
  logic        last_byte;

  assign next_idx  = byte_idx + 1'b1;
  // Past the end of the array only on the last byte of a full message
  assign next_byte = (next_idx < MAX_MSG_BYTES) ? msg_q[next_idx] : '0;
  assign half_end  = (half_cnt == HALF_LAST);
  assign last_byte = (next_idx == len_q);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy     <= 1'b0;
      tail     <= 1'b0;
      n_ss     <= 1'b1;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      spi_done <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      byte_idx <= '0;
    end else begin
      spi_done <= 1'b0;
      if (!busy) begin
        if (spi_start) begin
          // Select the chip and put the first bit out before any clock
          busy     <= 1'b1;
          n_ss     <= 1'b0;
          sclk     <= 1'b0;
          mosi     <= msg[0][7];
          half_cnt <= '0;
          bit_cnt  <= '0;
          byte_idx <= '0;
        end
      end else if (tail) begin
        // One hold cycle after the last falling edge, then deselect
        busy     <= 1'b0;
        tail     <= 1'b0;
        n_ss     <= 1'b1;
        spi_done <= 1'b1;
      end else begin
        half_cnt <= half_end ? '0 : half_cnt + 1'b1;
        if (half_end) begin
          sclk <= ~sclk;
          // Falling edge, move MOSI to the next bit
          if (sclk) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              byte_idx <= next_idx;
              if (last_byte) begin
                tail <= 1'b1;
                mosi <= 1'b0;
              end else begin
                mosi <= next_byte[7];
              end
            end else begin
              mosi <= tx_shift[6];
            end
          end
        end
      end
    end
  end

  // Data path, no reset needed
  always_ff @(posedge clk_in) begin
    if (!busy && spi_start) begin
      msg_q    <= msg;
      len_q    <= msg_len;
      tx_shift <= msg[0];
    end else if (busy && !tail && half_end) begin
      if (!sclk) begin
        // Rising edge, MISO sampled MSB first
        rx_shift <= {rx_shift[6:0], miso};
      end else if (bit_cnt == 3'd7) begin
        tx_shift <= next_byte;
        // First byte back is the chip status, second the register value
        if (byte_idx == 4'd0) begin
          rx_status <= rx_shift;
        end
        if (byte_idx == 4'd1) begin
          rx_value <= rx_shift;
        end
      end else begin
        tx_shift <= tx_shift << 1;
      end
    end
  end

endmodule

// ==== hdl/host_sequencer.sv ====
`timescale 1ns/1ns

module host_sequencer (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   spi_done,
  input  max3421_pkg::msg_byte_t rx_status,
  input  max3421_pkg::msg_byte_t rx_value,
  output max3421_pkg::cmd_t      cmd,
  output logic                   spi_start,
  output logic                   n_rst,
  output logic [15:0]            bytes_out
);
  import max3421_pkg::*;

  typedef enum logic [4:0] {
    S_BOOT,
    S_FULLDUPLEX,
    S_CHIP_RESET,
    S_CHIP_UNRESET,
    S_OSC_POLL,
    S_POWER,
    S_HOSTMODE,
    S_IRQ_ENABLE,
    S_SAMPLEBUS,
    S_SETTLE,
    S_BUSRESET,
    S_BUSRESET_POLL,
    S_SETTLE_2,
    S_SOF,
    S_SOF_POLL,
    S_SOF_SETTLE,
    S_SETUP_LOAD,
    S_FIFO_GAP,
    S_HXFR_SETUP,
    S_XFR_WAIT,
    S_CLEAR_SETUP,
    S_HXFR_STATUS,
    S_STATUS_GAP,
    S_READ_HRSL,
    S_CLEAR_STATUS,
    S_ADDR_REST,
    S_PERADDR,
    S_IDLE
  } state_t;

  state_t      state;
  // Shared delay counter for all timer states
  wait_count_t wait_cnt;
  // Set on entry to a transaction state, cleared once the start goes out
  logic        launch;
  // Keeps n_ss high long enough between frames
  gap_count_t  gap_cnt;

  // Message for the current state
  always_comb begin
    case (state)
      S_CHIP_RESET:    cmd = CMD_CHIP_RESET;
      S_CHIP_UNRESET:  cmd = CMD_CHIP_UNRESET;
      S_OSC_POLL:      cmd = CMD_READ_USBIRQ;
      S_POWER:         cmd = CMD_POWER;
      S_HOSTMODE:      cmd = CMD_HOSTMODE;
      S_IRQ_ENABLE:    cmd = CMD_IRQ_ENABLE;
      S_SAMPLEBUS:     cmd = CMD_SAMPLEBUS;
      S_BUSRESET:      cmd = CMD_BUSRESET;
      S_BUSRESET_POLL: cmd = CMD_READ_HCTL;
      S_SOF:           cmd = CMD_SOF;
      S_SOF_POLL:      cmd = CMD_READ_HIRQ;
      S_SETUP_LOAD:    cmd = CMD_SETUP_ADDR;
      S_HXFR_SETUP:    cmd = CMD_HXFR_SETUP;
      S_CLEAR_SETUP,
      S_CLEAR_STATUS:  cmd = CMD_CLEAR_HIRQ;
      S_HXFR_STATUS:   cmd = CMD_HXFR_STATUS;
      S_READ_HRSL:     cmd = CMD_READ_HRSL;
      S_PERADDR:       cmd = CMD_WRITE_PERADDR;
      default:         cmd = CMD_FULLDUPLEX;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= S_BOOT;
      wait_cnt  <= '0;
      launch    <= 1'b0;
      gap_cnt   <= SPI_GAP_CYCLES;
      spi_start <= 1'b0;
      n_rst     <= 1'b0;
      bytes_out <= '0;
    end else begin
      spi_start <= 1'b0;
      // Reload the deselect gap at the end of every frame
      if (spi_done) begin
        gap_cnt <= SPI_GAP_CYCLES;
      end else if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
      if (launch && gap_cnt == '0) begin
        spi_start <= 1'b1;
        launch    <= 1'b0;
      end

      case (state)
        // Release the chip reset pin, then start the power-up writes
        S_BOOT: begin
          n_rst  <= 1'b1;
          state  <= S_FULLDUPLEX;
          launch <= 1'b1;
        end
        S_FULLDUPLEX: if (spi_done) begin
          state  <= S_CHIP_RESET;
          launch <= 1'b1;
        end
        S_CHIP_RESET: if (spi_done) begin
          state  <= S_CHIP_UNRESET;
          launch <= 1'b1;
        end
        S_CHIP_UNRESET: if (spi_done) begin
          state  <= S_OSC_POLL;
          launch <= 1'b1;
        end
        // Oscillator must be running before host mode sticks
        S_OSC_POLL: if (spi_done) begin
          if (rx_value[OSCOKIRQ_BIT]) begin
            state <= S_POWER;
          end
          launch <= 1'b1;
        end
        S_POWER: if (spi_done) begin
          state  <= S_HOSTMODE;
          launch <= 1'b1;
        end
        S_HOSTMODE: if (spi_done) begin
          state  <= S_IRQ_ENABLE;
          launch <= 1'b1;
        end
        S_IRQ_ENABLE: if (spi_done) begin
          state  <= S_SAMPLEBUS;
          launch <= 1'b1;
        end
        S_SAMPLEBUS: if (spi_done) begin
          state <= S_SETTLE;
        end
        // Bus settle before the reset
        S_SETTLE: if (wait_cnt == SETTLE_CYCLES) begin
          wait_cnt <= '0;
          state    <= S_BUSRESET;
          launch   <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        S_BUSRESET: if (spi_done) begin
          state  <= S_BUSRESET_POLL;
          launch <= 1'b1;
        end
        // BUSRST self-clears when the chip finishes the reset
        S_BUSRESET_POLL: if (spi_done) begin
          if (!rx_value[BUSRST_BIT]) begin
            state <= S_SETTLE_2;
          end else begin
            launch <= 1'b1;
          end
        end
        S_SETTLE_2: if (wait_cnt == SETTLE_CYCLES) begin
          wait_cnt <= '0;
          state    <= S_SOF;
          launch   <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        S_SOF: if (spi_done) begin
          state  <= S_SOF_POLL;
          launch <= 1'b1;
        end
        // Wait for the first frame
        S_SOF_POLL: if (spi_done) begin
          bytes_out <= {rx_status, rx_value};
          if (rx_value[FRAMEIRQ_BIT]) begin
            state <= S_SOF_SETTLE;
          end else begin
            launch <= 1'b1;
          end
        end
        S_SOF_SETTLE: if (wait_cnt == SOF_SETTLE_CYCLES) begin
          wait_cnt <= '0;
          state    <= S_SETUP_LOAD;
          launch   <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        // SET_ADDRESS control transfer
        S_SETUP_LOAD: if (spi_done) begin
          state <= S_FIFO_GAP;
        end
        S_FIFO_GAP: if (wait_cnt == FIFO_GAP_CYCLES) begin
          wait_cnt <= '0;
          state    <= S_HXFR_SETUP;
          launch   <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        S_HXFR_SETUP: if (spi_done) begin
          state <= S_XFR_WAIT;
        end
        // Device response time to the SETUP token
        S_XFR_WAIT: if (wait_cnt == XFR_WAIT_CYCLES) begin
          wait_cnt <= '0;
          state    <= S_CLEAR_SETUP;
          launch   <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        S_CLEAR_SETUP: if (spi_done) begin
          state  <= S_HXFR_STATUS;
          launch <= 1'b1;
        end
        S_HXFR_STATUS: if (spi_done) begin
          state <= S_STATUS_GAP;
        end
        S_STATUS_GAP: if (wait_cnt == STATUS_GAP_CYCLES) begin
          wait_cnt <= '0;
          state    <= S_READ_HRSL;
          launch   <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        // NAK resends the handshake, any other failure reads again
        S_READ_HRSL: if (spi_done) begin
          bytes_out <= {rx_status, rx_value};
          launch    <= 1'b1;
          if (rx_value[3:0] == HRSLT_SUCCESS) begin
            state <= S_CLEAR_STATUS;
          end else if (rx_value[3:0] == HRSLT_NAK) begin
            state <= S_HXFR_STATUS;
          end
        end
        S_CLEAR_STATUS: if (spi_done) begin
          state <= S_ADDR_REST;
        end
        // Recovery time the device gets before the new address applies
        S_ADDR_REST: if (wait_cnt == ADDR_REST_CYCLES) begin
          wait_cnt <= '0;
          state    <= S_PERADDR;
          launch   <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        S_PERADDR: if (spi_done) begin
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/usb_host_top.sv ====
`timescale 1ns/1ns

module usb_host_top (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        miso,
  output logic        n_rst,
  output logic        n_ss,
  output logic        sclk,
  output logic        mosi,
  output logic [15:0] bytes_out
);
  import max3421_pkg::*;

  // Sequencer to message table
  cmd_t       cmd;
  msg_bytes_t msg;
  msg_len_t   msg_len;

  // Sequencer to SPI master
  logic       spi_start;
  logic       spi_done;
  msg_byte_t  rx_status;
  msg_byte_t  rx_value;

  host_sequencer seq_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .spi_done  (spi_done),
    .rx_status (rx_status),
    .rx_value  (rx_value),
    .cmd       (cmd),
    .spi_start (spi_start),
    .n_rst     (n_rst),
    .bytes_out (bytes_out)
  );

  max3421_msg_rom rom_i (
    .cmd     (cmd),
    .msg     (msg),
    .msg_len (msg_len)
  );

  // Chip SPI port, mode 0
  max3421_spi spi_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .spi_start (spi_start),
    .msg       (msg),
    .msg_len   (msg_len),
    .miso      (miso),
    .sclk      (sclk),
    .mosi      (mosi),
    .n_ss      (n_ss),
    .spi_done  (spi_done),
    .rx_status (rx_status),
    .rx_value  (rx_value)
  );

endmodule

// ==== tests/max3421_model.sv ====
`timescale 1ns/1ns

module max3421_model (
  input  logic             sclk,
  input  logic             mosi,
  input  logic             n_ss,
  input  logic [7:0]       rd_status,
  input  logic [7:0]       rd_value,
  output logic             miso,
  output logic [8:0][7:0]  frame_bytes,
  output int               frame_bits,
  output int               frame_count,
  output logic             frame_err
);

  // Response shifter, status byte first then register value
  logic [15:0]      tx_q = '0;
  logic             miso_q = 1'b0;
  // Bytes seen on MOSI during the current frame, command byte at index 0
  logic [8:0][7:0]  bytes_q = '0;
  int               bits_q = 0;
  int               last_bits_q = 0;
  int               count_q = 0;
  // SCLK must idle low at both n_ss edges
  logic             err_q = 1'b0;

  assign miso        = miso_q;
  assign frame_bytes = bytes_q;
  assign frame_bits  = last_bits_q;
  assign frame_count = count_q;
  assign frame_err   = err_q;

  // Frame start, first response bit goes out before any clock
  always @(negedge n_ss) begin
    err_q   = sclk;
    tx_q    = {rd_status, rd_value};
    miso_q  = tx_q[15];
    bits_q  = 0;
    bytes_q = '0;
  end

  // Mode 0, MOSI sampled on the rising edge MSB first
  always @(posedge sclk) begin
    if (!n_ss) begin
      if (bits_q < 72) begin
        bytes_q[bits_q / 8][7 - (bits_q % 8)] = mosi;
      end
      bits_q = bits_q + 1;
    end
  end

  // MISO moves on the falling edge, zeros after the second byte
  always @(negedge sclk) begin
    if (!n_ss) begin
      tx_q   = tx_q << 1;
      miso_q = tx_q[15];
    end
  end

  // Frame end, publish the bit count and bump the frame counter
  always @(posedge n_ss) begin
    if (sclk) begin
      err_q = 1'b1;
    end
    last_bits_q = bits_q;
    count_q    <= count_q + 1;
  end

endmodule

// ==== tests/tb_usb_host_top.sv ====
`timescale 1ns/1ns

module tb_usb_host_top;
  import max3421_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int MAX_RECORDS = 64;
  localparam int TIMER_SUM   = int'(SETTLE_CYCLES) + int'(SOF_SETTLE_CYCLES) +
                               int'(FIFO_GAP_CYCLES) + int'(XFR_WAIT_CYCLES) +
                               int'(STATUS_GAP_CYCLES) + int'(ADDR_REST_CYCLES);

  logic            clk_in;
  logic            rst_in;
  logic            miso;
  logic            n_rst;
  logic            n_ss;
  logic            sclk;
  logic            mosi;
  logic [15:0]     bytes_out;
  logic [7:0]      rd_status = '0;
  logic [7:0]      rd_value = '0;
  logic [8:0][7:0] frame_bytes;
  int              frame_bits;
  int              frame_count;
  logic            frame_err;

  // Raw stimulus file image
  logic [87:0]     mem [0:MAX_RECORDS-1];

  // Records from the stimulus file, one queue per record type
  logic [87:0]     write_q[$];
  logic [87:0]     read_q[$];
  logic [87:0]     disp_q[$];

  string           test_names[NUM_TESTS];
  int              errors[NUM_TESTS];
  int              cur_test;
  int              reg_reads[32];
  int              scripted_reads[32];
  int              hxfr_status_writes;
  int              nak_scripted;
  int              hrsl_fail_reads;
  int              hrsl_fail_scripted;
  int              seen_frames;
  logic [4:0]      last_addr;
  logic [7:0]      last_data;
  int              cycles = 0;
  int              cycle_limit = 0;

  usb_host_top dut_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .miso      (miso),
    .n_rst     (n_rst),
    .n_ss      (n_ss),
    .sclk      (sclk),
    .mosi      (mosi),
    .bytes_out (bytes_out)
  );

  max3421_model model_i (
    .sclk        (sclk),
    .mosi        (mosi),
    .n_ss        (n_ss),
    .rd_status   (rd_status),
    .rd_value    (rd_value),
    .miso        (miso),
    .frame_bytes (frame_bytes),
    .frame_bits  (frame_bits),
    .frame_count (frame_count),
    .frame_err   (frame_err)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  // Hard stop well past the longest legal run
  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the controller never finished", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors[cur_test] = errors[cur_test] + 1;
      $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic note_error(input string what);
    errors[cur_test] = errors[cur_test] + 1;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic report_test(input int idx);
    if (errors[idx] == 0) begin
      $display("test %s: ok", test_names[idx]);
    end else begin
      $display("test %s: %0d errors", test_names[idx], errors[idx]);
    end
  endtask

  task automatic load_stimulus();
    int i;
    for (i = 0; i < MAX_RECORDS; i++) begin
      mem[i] = '0;
    end
    $readmemh("tests/usb_host_stimulus.txt", mem);
    for (i = 0; i < MAX_RECORDS; i++) begin
      case (mem[i][87:80])
        8'h01: write_q.push_back(mem[i]);
        8'h02: begin
          read_q.push_back(mem[i]);
          scripted_reads[mem[i][76:72]]++;
          // HRSLT codes scripted for the status stage
          if (mem[i][76:72] == REG_HRSL && mem[i][51:48] == HRSLT_NAK) begin
            nak_scripted++;
          end
          if (mem[i][76:72] == REG_HRSL && mem[i][51:48] != HRSLT_SUCCESS) begin
            hrsl_fail_scripted++;
          end
        end
        8'h03: disp_q.push_back(mem[i]);
        default: ;
      endcase
    end
  endtask

  // Next scripted read answer, presented before the next n_ss fall
  task automatic update_response();
    if (read_q.size() > 0) begin
      rd_status = read_q[0][63:56];
      rd_value  = read_q[0][55:48];
    end else begin
      rd_status = '0;
      rd_value  = '0;
    end
  endtask

  task automatic check_write(input logic [4:0] addr, input int len);
    logic [87:0] rec;
    int          i;
    if (write_q.size() == 0) begin
      note_error($sformatf("unexpected write to register %0d", addr));
    end else begin
      rec = write_q.pop_front();
      check("write register", 32'(addr), 32'(rec[76:72]));
      check("write length", 32'(len), 32'(rec[71:64]));
      for (i = 1; i < len && i < MAX_MSG_BYTES; i++) begin
        check($sformatf("write byte %0d", i), 32'(frame_bytes[i]),
              32'(rec[63 - 8 * (i - 1) -: 8]));
      end
    end
    if (addr == REG_HXFR && frame_bytes[1] == 8'h80) begin
      hxfr_status_writes++;
    end
    last_addr = addr;
    last_data = frame_bytes[1];
  endtask

  task automatic check_read(input logic [4:0] addr, input int len);
    logic [87:0] rec;
    check("read length", 32'(len), 32'd2);
    check("read data byte", 32'(frame_bytes[1]), 32'd0);
    reg_reads[addr]++;
    if (read_q.size() == 0) begin
      note_error($sformatf("read of register %0d with no scripted response", addr));
    end else begin
      rec = read_q.pop_front();
      check("read register order", 32'(addr), 32'(rec[76:72]));
      if (addr == REG_HRSL && rec[51:48] != HRSLT_SUCCESS) begin
        hrsl_fail_reads++;
      end
    end
    update_response();
    // Display follows the done pulse by one clock
    if (addr == REG_HIRQ || addr == REG_HRSL) begin
      cur_test = 4;
      @(negedge clk_in);
      @(negedge clk_in);
      if (disp_q.size() == 0) begin
        note_error("status display changed with no expected value left");
      end else begin
        rec = disp_q.pop_front();
        check("bytes_out", 32'(bytes_out), 32'(rec[63:48]));
      end
    end
  endtask

  task automatic handle_frame();
    logic [7:0] cmd_b;
    int         len;
    cmd_b = frame_bytes[0];
    len = frame_bits / 8;
    cur_test = 1;
    check("frame bit count", 32'(frame_bits % 8), 32'd0);
    check("sclk low at n_ss edges", 32'(frame_err), 32'd0);
    if (cmd_b[DIR_WRITE]) begin
      check_write(cmd_b[7:3], len);
    end else begin
      cur_test = 2;
      check_read(cmd_b[7:3], len);
    end
  endtask

  initial begin
    int i;
    int failed;
    int total;
    test_names[0] = "reset";
    test_names[1] = "register writes";
    test_names[2] = "poll loops";
    test_names[3] = "nak retry";
    test_names[4] = "status display";
    test_names[5] = "completion";
    for (i = 0; i < NUM_TESTS; i++) begin
      errors[i] = 0;
    end
    for (i = 0; i < 32; i++) begin
      reg_reads[i] = 0;
      scripted_reads[i] = 0;
    end
    hxfr_status_writes = 0;
    nak_scripted = 0;
    hrsl_fail_reads = 0;
    hrsl_fail_scripted = 0;
    rst_in = 1'b1;
    load_stimulus();
    update_response();
    cycle_limit = 2 * TIMER_SUM +
                  (write_q.size() + read_q.size()) * 9 * 16 * SPI_HALF_CYCLES;

    // Reset held for 8 cycles
    cur_test = 0;
    repeat (8) begin
      @(negedge clk_in);
      check("n_ss in reset", 32'(n_ss), 32'd1);
      check("sclk in reset", 32'(sclk), 32'd0);
      check("bytes_out in reset", 32'(bytes_out), 32'd0);
      check("n_rst in reset", 32'(n_rst), 32'd0);
    end
    rst_in = 1'b0;
    @(negedge clk_in);
    check("n_ss after reset", 32'(n_ss), 32'd1);
    check("sclk after reset", 32'(sclk), 32'd0);
    check("bytes_out after reset", 32'(bytes_out), 32'd0);
    check("n_rst after reset", 32'(n_rst), 32'd1);
    report_test(0);

    // Walk every frame until the expected write list is used up
    seen_frames = frame_count;
    while (write_q.size() > 0) begin
      while (frame_count == seen_frames) begin
        @(negedge clk_in);
      end
      seen_frames++;
      handle_frame();
    end
    report_test(1);

    cur_test = 2;
    for (i = 0; i < 32; i++) begin
      check($sformatf("reads of register %0d", i), 32'(reg_reads[i]),
            32'(scripted_reads[i]));
    end
    report_test(2);

    cur_test = 3;
    check("HXFR status writes", 32'(hxfr_status_writes), 32'(nak_scripted + 1));
    check("failed HRSL reads", 32'(hrsl_fail_reads), 32'(hrsl_fail_scripted));
    report_test(3);

    cur_test = 4;
    check("display values left", 32'(disp_q.size()), 32'd0);
    report_test(4);

    // Last write sets the address, then the bus stays quiet
    cur_test = 5;
    check("last write register", 32'(last_addr), 32'(REG_PERADDR));
    check("last write data", 32'(last_data), 32'(PERIPH_ADDR));
    repeat (int'(ADDR_REST_CYCLES)) @(negedge clk_in);
    check("frames after completion", 32'(frame_count), 32'(seen_frames));
    check("n_ss idle", 32'(n_ss), 32'd1);
    report_test(5);

    failed = 0;
    total = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      total = total + errors[i];
      if (errors[i] != 0) begin
        failed++;
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, NUM_TESTS - failed, failed, total);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/usb_host_stimulus.txt ====
// Columns: type(2) register(2) length(2) data(16), hex with no spaces
// Type 01 expected write, 02 read response status then value, 03 expected bytes_out
0111021400000000000000
010F022000000000000000
010F020000000000000000
0114020100000000000000
011B02D900000000000000
011A026000000000000000
011D020400000000000000
011D020100000000000000
011B02D900000000000000
0104090005010000000000
011E021000000000000000
011902E000000000000000
011E028000000000000000
011E028000000000000000
011902E000000000000000
011C020100000000000000
020D020000000000000000
020D020001000000000000
021D020001000000000000
021D020001000000000000
021D020000000000000000
0219020800000000000000
0219024840000000000000
021F028004000000000000
021F02800E000000000000
021F02C000000000000000
0300000800000000000000
0300004840000000000000
0300008004000000000000
030000800E000000000000
030000C000000000000000

// ==== usb_host_top.f ====
hdl/max3421_pkg.sv
hdl/max3421_msg_rom.sv
hdl/max3421_spi.sv
hdl/host_sequencer.sv
hdl/usb_host_top.sv
tests/max3421_model.sv
tests/tb_usb_host_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_usb_host_top
FILELIST  ?= usb_host_top.f
BIN       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
